/* common/npc_params.svh */
// core-wide widths and the reset pc, included by any file that sizes a datapath or a register
`ifndef NPC_PARAMS_SVH
`define NPC_PARAMS_SVH

// ****************************************
// datapath
// ****************************************

// data and pc width
`define NPC_XLEN 64

// number of general registers
`define NPC_NREG 32

// ****************************************
// reset
// ****************************************

// first fetch address after reset
`define NPC_RESET_PC 64'h0

`endif

/* common/npc_pkg.sv */
// shared types of the core, referenced by scoped name from every stage and the top level
`include "npc_params.svh"

package npc_pkg;

	// ****************************************
	// scalar types
	// ****************************************

	// one data word or one pc
	typedef logic [`NPC_XLEN-1:0] xlen_t;

	// general register index
	typedef logic [$clog2(`NPC_NREG)-1:0] reg_addr_t;

	// operation selected by decode, carried to execute
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		// lui just forwards operand b
		alu_pass_b = 4'd5,
		alu_jal    = 4'd6,
		alu_beq    = 4'd7,
		alu_bne    = 4'd8,
		alu_nop    = 4'd9
	} alu_op_t;

	// ****************************************
	// stage payloads
	// ****************************************

	// fetch to decode
	typedef struct packed {
		xlen_t       pc;
		logic [31:0] inst;
	} fetch_pkt_t;

	// decode to execute, operand b already holds the i/u immediate
	typedef struct packed {
		xlen_t     pc;
		alu_op_t   op;
		xlen_t     a;
		xlen_t     b;
		// branch or jump offset
		xlen_t     imm;
		reg_addr_t rd;
		logic      wen;
	} issue_pkt_t;

	// execute to writeback
	typedef struct packed {
		xlen_t     pc;
		reg_addr_t rd;
		logic      wen;
		xlen_t     value;
	} wb_pkt_t;

endpackage

/* common/stage_if.sv */
// valid/ready link between two pipeline stages, instantiated once per payload type
interface stage_if #(
	parameter type payload_t = logic
) ();

	// producer has a packet this cycle
	logic valid;

	// consumer takes it at the next edge
	logic ready;

	// packet body, stable while valid and not yet taken
	payload_t payload;

	// ****************************************
	// views
	// ****************************************

	// producing stage
	modport src (
		output valid,
		output payload,
		input  ready
	);

	// consuming stage
	modport dst (
		input  valid,
		input  payload,
		output ready
	);

endinterface

/* design/regfile.sv */
// general register file with two combinational read ports and one synchronous write port
`include "npc_params.svh"

module regfile (
	input  logic               clk,
	input  npc_pkg::reg_addr_t raddr_a,
	input  npc_pkg::reg_addr_t raddr_b,
	output npc_pkg::xlen_t     rdata_a,
	output npc_pkg::xlen_t     rdata_b,
	input  logic               wen,
	input  npc_pkg::reg_addr_t waddr,
	input  npc_pkg::xlen_t     wdata
);

	// storage, entry 0 is never written
	npc_pkg::xlen_t regs [`NPC_NREG];

	// ****************************************
	// write port
	// ****************************************

	// x0 is hardwired, drop writes to it
	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// ****************************************
	// read ports
	// ****************************************

	// x0 reads zero
	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];

	// same for port b
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* design/scoreboard.sv */
// busy bit per general register, marks a write that has issued but not yet written back
`include "npc_params.svh"

module scoreboard (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  npc_pkg::reg_addr_t  issue_rd,
	input  logic                wb_wen,
	input  npc_pkg::reg_addr_t  wb_rd,
	output logic [`NPC_NREG-1:0] busy
);

	// ****************************************
	// busy bits
	// ****************************************

	// set on issue, cleared on writeback
	// decode stalls on a busy rd, so both never hit the same bit
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
		end else begin
			// x0 never becomes busy
			if (issue && issue_rd != '0) begin
				busy[issue_rd] <= 1'b1;
			end
			// result lands in the register file at this same edge
			if (wb_wen && wb_rd != '0) begin
				busy[wb_rd] <= 1'b0;
			end
		end
	end

endmodule

/* ifu/ifu.sv */
// fetch stage, drives the fetch address and buffers one instruction toward decode
`include "npc_params.svh"

module ifu (
	input  logic           clk,
	input  logic           rst,
	output npc_pkg::xlen_t pc,
	input  logic [31:0]    inst,
	input  logic           redirect,
	input  npc_pkg::xlen_t redirect_pc,
	stage_if.src           id
);

	// fetch address
	npc_pkg::xlen_t pc_q;

	// one-entry buffer toward decode
	logic                pkt_valid;
	npc_pkg::fetch_pkt_t pkt_q;

	// buffer empty or handing off this cycle
	logic advance;

	assign advance = !pkt_valid || id.ready;

	// ****************************************
	// pc and buffer control
	// ****************************************

	// redirect drops the held packet, the target is fetched next cycle
	// under back-pressure pc and packet both hold
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q      <= `NPC_RESET_PC;
			pkt_valid <= 1'b0;
		end else if (redirect) begin
			pc_q      <= redirect_pc;
			pkt_valid <= 1'b0;
		end else if (advance) begin
			pc_q      <= pc_q + npc_pkg::xlen_t'(4);
			pkt_valid <= 1'b1;
		end
	end

	// inst belongs to the pc presented this cycle
	always_ff @(posedge clk) begin
		if (!redirect && advance) begin
			pkt_q.pc   <= pc_q;
			pkt_q.inst <= inst;
		end
	end

	// ****************************************
	// outputs
	// ****************************************
	assign pc         = pc_q;
	assign id.valid   = pkt_valid;
	assign id.payload = pkt_q;

endmodule

/* idu/idu.sv */
// decode stage: field decode, immediates, operand read, hazard stall and issue to execute
`include "npc_params.svh"

module idu (
	input  logic                 clk,
	input  logic                 rst,
	stage_if.dst                 fd,
	stage_if.src                 ex,
	output npc_pkg::reg_addr_t   rs1,
	output npc_pkg::reg_addr_t   rs2,
	input  npc_pkg::xlen_t       rs1_val,
	input  npc_pkg::xlen_t       rs2_val,
	input  logic [`NPC_NREG-1:0] busy,
	output logic                 issue,
	output npc_pkg::reg_addr_t   issue_rd,
	input  logic                 redirect
);

	// instruction fields
	logic [31:0]        inst;
	logic [6:0]         opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	npc_pkg::reg_addr_t rd;

	// sign-extended immediates
	npc_pkg::xlen_t imm_i;
	npc_pkg::xlen_t imm_u;
	npc_pkg::xlen_t imm_b;
	npc_pkg::xlen_t imm_j;

	// decoded packet and which sources it reads
	npc_pkg::issue_pkt_t dec;
	logic                use_rs1;
	logic                use_rs2;

	// output register
	npc_pkg::issue_pkt_t out_q;
	logic                out_valid;

	// handshake helpers
	logic pend;
	logic hazard;
	logic out_free;
	logic take;

	assign inst   = fd.payload.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	// ****************************************
	// immediates
	// ****************************************
	assign imm_i = {{(`NPC_XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {{(`NPC_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_b = {{(`NPC_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{(`NPC_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
		1'b0};

	// ****************************************
	// decode
	// ****************************************

	// anything not matched leaves a nop that writes nothing
	always_comb begin
		dec.pc  = fd.payload.pc;
		dec.op  = npc_pkg::alu_nop;
		dec.a   = rs1_val;
		dec.b   = rs2_val;
		dec.imm = '0;
		dec.rd  = rd;
		dec.wen = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			// addi
			7'b0010011: begin
				if (funct3 == 3'b000) begin
					dec.op  = npc_pkg::alu_add;
					dec.b   = imm_i;
					dec.wen = 1'b1;
					use_rs1 = 1'b1;
				end
			end
			// register-register alu
			7'b0110011: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec.op = npc_pkg::alu_add;
					{7'b0100000, 3'b000}: dec.op = npc_pkg::alu_sub;
					{7'b0000000, 3'b111}: dec.op = npc_pkg::alu_and;
					{7'b0000000, 3'b110}: dec.op = npc_pkg::alu_or;
					{7'b0000000, 3'b100}: dec.op = npc_pkg::alu_xor;
					default:              dec.op = npc_pkg::alu_nop;
				endcase
				if (dec.op != npc_pkg::alu_nop) begin
					dec.wen = 1'b1;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			// lui
			7'b0110111: begin
				dec.op  = npc_pkg::alu_pass_b;
				dec.b   = imm_u;
				dec.wen = 1'b1;
			end
			// jal, link value formed in execute
			7'b1101111: begin
				dec.op  = npc_pkg::alu_jal;
				dec.imm = imm_j;
				dec.wen = 1'b1;
			end
			// beq and bne only
			7'b1100011: begin
				if (funct3 == 3'b000 || funct3 == 3'b001) begin
					dec.op  = (funct3 == 3'b000) ? npc_pkg::alu_beq : npc_pkg::alu_bne;
					dec.imm = imm_b;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			default: dec.op = npc_pkg::alu_nop;
		endcase
	end

	// ****************************************
	// hazard stall
	// ****************************************

	// held packet not yet accepted, so its rd is not marked busy yet
	assign pend = out_valid && out_q.wen && out_q.rd != '0;

	// stall on a busy source, or on a busy rd to keep writes in order
	assign hazard = (use_rs1 && rs1 != '0 && (busy[rs1] || (pend && out_q.rd == rs1)))
		|| (use_rs2 && rs2 != '0 && (busy[rs2] || (pend && out_q.rd == rs2)))
		|| (dec.wen && rd != '0 && (busy[rd] || (pend && out_q.rd == rd)));

	// ****************************************
	// output register
	// ****************************************
	assign out_free = !out_valid || ex.ready;

	// redirect refuses the wrong-path fetch packet
	assign fd.ready = out_free && !hazard && !redirect;
	assign take     = fd.valid && fd.ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (redirect) begin
			out_valid <= 1'b0;
		end else if (out_free) begin
			out_valid <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_q <= dec;
		end
	end

	assign ex.valid   = out_valid;
	assign ex.payload = out_q;

	// scoreboard set when execute takes a real write
	assign issue    = out_valid && ex.ready && out_q.wen && out_q.rd != '0;
	assign issue_rd = out_q.rd;

endmodule

/* exu/exu.sv */
// execute stage: alu, branch compare, jump target and link, redirect toward fetch and decode
module exu (
	input  logic           clk,
	input  logic           rst,
	stage_if.dst           id,
	stage_if.src           wb,
	output logic           redirect,
	output npc_pkg::xlen_t redirect_pc
);

	// packet offered by decode
	npc_pkg::issue_pkt_t iss;

	// alu output and branch decision
	npc_pkg::xlen_t result;
	logic           taken;

	// handshake on the input side
	logic accept;

	// one-entry output register toward writeback
	logic             wb_valid;
	npc_pkg::wb_pkt_t wb_q;

	assign iss      = id.payload;
	assign id.ready = !wb_valid || wb.ready;
	assign accept   = id.valid && id.ready;

	// ****************************************
	// alu and branch compare
	// ****************************************
	always_comb begin
		result = '0;
		taken  = 1'b0;
		case (iss.op)
			npc_pkg::alu_add:    result = iss.a + iss.b;
			npc_pkg::alu_sub:    result = iss.a - iss.b;
			npc_pkg::alu_and:    result = iss.a & iss.b;
			npc_pkg::alu_or:     result = iss.a | iss.b;
			npc_pkg::alu_xor:    result = iss.a ^ iss.b;
			npc_pkg::alu_pass_b: result = iss.b;
			// link is the next sequential pc, always taken
			npc_pkg::alu_jal: begin
				result = iss.pc + npc_pkg::xlen_t'(4);
				taken  = 1'b1;
			end
			npc_pkg::alu_beq:    taken = (iss.a == iss.b);
			npc_pkg::alu_bne:    taken = (iss.a != iss.b);
			default:             result = '0;
		endcase
	end

	// ****************************************
	// redirect
	// ****************************************

	// single pulse, only in the accepting cycle
	assign redirect    = accept && taken;
	assign redirect_pc = iss.pc + iss.imm;

	// ****************************************
	// output register
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else if (accept) begin
			wb_valid <= 1'b1;
		end else if (wb.ready) begin
			wb_valid <= 1'b0;
		end
	end

	// branches and nops go through with wen low
	always_ff @(posedge clk) begin
		if (accept) begin
			wb_q.pc    <= iss.pc;
			wb_q.rd    <= iss.rd;
			wb_q.wen   <= iss.wen;
			wb_q.value <= result;
		end
	end

	assign wb.valid   = wb_valid;
	assign wb.payload = wb_q;

endmodule

/* design/wbu.sv */
// writeback stage, drives the register file write port and reports each retired instruction
module wbu (
	input  logic               clk,
	input  logic               rst,
	stage_if.dst               ex,
	output logic               rf_wen,
	output npc_pkg::reg_addr_t rf_waddr,
	output npc_pkg::xlen_t     rf_wdata,
	output logic               commit_valid,
	output npc_pkg::xlen_t     commit_pc,
	output npc_pkg::reg_addr_t commit_rd,
	output logic               commit_wen,
	output npc_pkg::xlen_t     commit_value
);

	// accepted packet, held for one cycle
	logic             valid_q;
	npc_pkg::wb_pkt_t pkt_q;

	// never back-pressures execute
	assign ex.ready = 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= ex.valid && ex.ready;
		end
	end

	always_ff @(posedge clk) begin
		if (ex.valid && ex.ready) begin
			pkt_q <= ex.payload;
		end
	end

	// ****************************************
	// register write and commit report
	// ****************************************

	// x0 target counts as no write
	assign rf_wen   = valid_q && pkt_q.wen && pkt_q.rd != '0;
	assign rf_waddr = pkt_q.rd;
	assign rf_wdata = pkt_q.value;

	assign commit_valid = valid_q;
	assign commit_pc    = pkt_q.pc;
	assign commit_rd    = pkt_q.rd;
	assign commit_wen   = rf_wen;
	assign commit_value = pkt_q.value;

endmodule

/* design/npc.sv */
// core top level, connects the four stages, register file and scoreboard to plain ports
`include "npc_params.svh"

module npc (
	input  logic               clk,
	input  logic               rst,
	output npc_pkg::xlen_t     pc,
	input  logic [31:0]        inst,
	output logic               commit_valid,
	output npc_pkg::xlen_t     commit_pc,
	output npc_pkg::reg_addr_t commit_rd,
	output logic               commit_wen,
	output npc_pkg::xlen_t     commit_value
);

	// ****************************************
	// stage links
	// ****************************************
	stage_if #(.payload_t(npc_pkg::fetch_pkt_t)) if_id ();
	stage_if #(.payload_t(npc_pkg::issue_pkt_t)) id_ex ();
	stage_if #(.payload_t(npc_pkg::wb_pkt_t))    ex_wb ();

	// redirect from execute
	logic           redirect;
	npc_pkg::xlen_t redirect_pc;

	// register file read side
	npc_pkg::reg_addr_t rs1;
	npc_pkg::reg_addr_t rs2;
	npc_pkg::xlen_t     rs1_val;
	npc_pkg::xlen_t     rs2_val;

	// register file write side, also clears the scoreboard
	logic               rf_wen;
	npc_pkg::reg_addr_t rf_waddr;
	npc_pkg::xlen_t     rf_wdata;

	// scoreboard
	logic                 issue;
	npc_pkg::reg_addr_t   issue_rd;
	logic [`NPC_NREG-1:0] busy;

	// ****************************************
	// pipeline
	// ****************************************
	ifu i_ifu (
		.clk(clk), .rst(rst), .pc(pc), .inst(inst),
		.redirect(redirect), .redirect_pc(redirect_pc), .id(if_id.src)
	);

	idu i_idu (
		.clk(clk), .rst(rst), .fd(if_id.dst), .ex(id_ex.src),
		.rs1(rs1), .rs2(rs2), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.busy(busy), .issue(issue), .issue_rd(issue_rd), .redirect(redirect)
	);

	exu i_exu (
		.clk(clk), .rst(rst), .id(id_ex.dst), .wb(ex_wb.src),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	wbu i_wbu (
		.clk(clk), .rst(rst), .ex(ex_wb.dst),
		.rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
		.commit_wen(commit_wen), .commit_value(commit_value)
	);

	// ****************************************
	// register state
	// ****************************************
	regfile i_regfile (
		.clk(clk), .raddr_a(rs1), .raddr_b(rs2), .rdata_a(rs1_val), .rdata_b(rs2_val),
		.wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	scoreboard i_scoreboard (
		.clk(clk), .rst(rst), .issue(issue), .issue_rd(issue_rd),
		.wb_wen(rf_wen), .wb_rd(rf_waddr), .busy(busy)
	);

endmodule

/* tb/npc_tb.sv */
// drives the npc core from a program memory and checks each commit against a sequential model
`include "npc_params.svh"

module npc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// expected retirement where rd and value only matter with wen set
	typedef struct packed {
		logic [`NPC_XLEN-1:0] pc;
		logic [4:0]           rd;
		logic                 wen;
		logic [`NPC_XLEN-1:0] value;
	} commit_t;

	// addi x0, x0, 0
	localparam logic [31:0] nop_word = 32'h0000_0013;

	// register-register selectors
	localparam logic [2:0] rr_add = 3'd0;
	localparam logic [2:0] rr_sub = 3'd1;
	localparam logic [2:0] rr_and = 3'd2;
	localparam logic [2:0] rr_or  = 3'd3;
	localparam logic [2:0] rr_xor = 3'd4;

	logic                 clk;
	logic                 rst;
	logic [`NPC_XLEN-1:0] pc;
	logic [31:0]          inst;
	logic                 commit_valid;
	logic [`NPC_XLEN-1:0] commit_pc;
	logic [4:0]           commit_rd;
	logic                 commit_wen;
	logic [`NPC_XLEN-1:0] commit_value;

	// program memory of 64 words from address 0
	logic [31:0]          prog [64];
	logic [`NPC_XLEN-1:0] prog_end;
	int                   load_count;

	// checking state
	commit_t exp_q [$];
	int      exp_count;
	int      commit_cnt;
	int      errors;
	int      tests;
	int      passed;
	logic    rst_q;
	logic [31:0] lfsr;

	// watchdog limit grows with each loaded test
	int budget = 20;
	int cycles;

	npc i_npc (
		.clk(clk), .rst(rst), .pc(pc), .inst(inst),
		.commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
		.commit_wen(commit_wen), .commit_value(commit_value)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ****************************************
	// instruction encoders
	// ****************************************
	function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] rr_op(input logic [2:0] sel, input logic [4:0] rd, rs1, rs2);
		logic [9:0] f;
		// funct7 then funct3
		case (sel)
			rr_add:  f = {7'h00, 3'b000};
			rr_sub:  f = {7'h20, 3'b000};
			rr_and:  f = {7'h00, 3'b111};
			rr_or:   f = {7'h00, 3'b110};
			default: f = {7'h00, 3'b100};
		endcase
		return {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// funct3 0 is beq and 1 is bne
	function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
		input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	task automatic emit(input logic [31:0] ins);
		prog[prog_end[7:2]] = ins;
		prog_end = prog_end + 64'd4;
	endtask

	// ****************************************
	// lfsr with taps x^32 + x^22 + x^2 + x + 1
	// ****************************************
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// ****************************************
	// program memory
	// ****************************************

	// outside the loaded program everything reads as a nop
	function automatic logic [31:0] fetch_word(input logic [`NPC_XLEN-1:0] addr);
		if (addr < prog_end) begin
			return prog[addr[7:2]];
		end
		return nop_word;
	endfunction

	// inst follows pc 2 ns later and a reload retriggers it
	initial begin
		inst = nop_word;
		forever begin
			@(pc or load_count);
			#2;
			inst = fetch_word(pc);
		end
	end

	// ****************************************
	// reference model
	// ****************************************

	// runs the program in order from the reset pc and queues every retirement
	task automatic run_model();
		logic [`NPC_XLEN-1:0] r [32];
		logic [`NPC_XLEN-1:0] mpc;
		logic [`NPC_XLEN-1:0] nxt;
		logic [`NPC_XLEN-1:0] a;
		logic [`NPC_XLEN-1:0] b;
		logic [`NPC_XLEN-1:0] val;
		logic [31:0]          ins;
		logic                 wen;
		commit_t              c;
		int                   steps;
		exp_q.delete();
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		mpc = `NPC_RESET_PC;
		steps = 0;
		while (mpc < prog_end && steps < 256) begin
			ins = prog[mpc[7:2]];
			a = r[ins[19:15]];
			b = r[ins[24:20]];
			nxt = mpc + 64'd4;
			val = '0;
			wen = 1'b0;
			case (ins[6:0])
				// addi only among the immediate forms
				7'b0010011: begin
					if (ins[14:12] == 3'b000) begin
						val = a + 64'($signed(ins[31:20]));
						wen = 1'b1;
					end
				end
				7'b0110011: begin
					wen = 1'b1;
					case ({ins[31:25], ins[14:12]})
						10'b0000000_000: val = a + b;
						10'b0100000_000: val = a - b;
						10'b0000000_111: val = a & b;
						10'b0000000_110: val = a | b;
						10'b0000000_100: val = a ^ b;
						default:         wen = 1'b0;
					endcase
				end
				7'b0110111: begin
					val = 64'($signed({ins[31:12], 12'h000}));
					wen = 1'b1;
				end
				// link is the next sequential pc
				7'b1101111: begin
					val = mpc + 64'd4;
					wen = 1'b1;
					nxt = mpc + 64'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
				end
				7'b1100011: begin
					if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
						nxt = mpc + 64'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
					end
				end
				default: wen = 1'b0;
			endcase
			c.pc = mpc;
			c.rd = ins[11:7];
			c.wen = wen && ins[11:7] != 5'd0;
			c.value = val;
			exp_q.push_back(c);
			if (c.wen) begin
				r[ins[11:7]] = val;
			end
			mpc = nxt;
			steps++;
		end
		exp_count = exp_q.size();
		// nops fetched past the end may retire before the next reset lands
		for (int i = 0; i < 4; i++) begin
			c.pc = mpc;
			c.rd = 5'd0;
			c.wen = 1'b0;
			c.value = '0;
			exp_q.push_back(c);
			mpc = mpc + 64'd4;
		end
	endtask

	// ****************************************
	// commit checks
	// ****************************************
	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("FAIL %s: got %h, expected %h", name, got, exp);
		errors++;
	endtask

	always @(posedge clk) begin
		rst_q <= rst;
	end

	// registered outputs are stable at the falling edge
	always @(negedge clk) begin
		commit_t e;
		if (rst && rst_q) begin
			assert (commit_valid === 1'b0)
				else report_mismatch("commit_valid", 64'(commit_valid), 64'd0);
			assert (pc === `NPC_RESET_PC)
				else report_mismatch("pc", pc, `NPC_RESET_PC);
		end else if (!rst && commit_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("unexpected retirement at pc %h after the expected sequence", commit_pc);
				errors++;
			end else begin
				e = exp_q.pop_front();
				// first retirement after reset
				if (commit_cnt == 0) begin
					assert (commit_pc === `NPC_RESET_PC)
						else report_mismatch("commit_pc", commit_pc, `NPC_RESET_PC);
				end
				assert (commit_pc === e.pc) else report_mismatch("commit_pc", commit_pc, e.pc);
				assert (commit_wen === e.wen)
					else report_mismatch("commit_wen", 64'(commit_wen), 64'(e.wen));
				if (e.wen) begin
					assert (commit_rd === e.rd)
						else report_mismatch("commit_rd", 64'(commit_rd), 64'(e.rd));
					assert (commit_value === e.value)
						else report_mismatch("commit_value", commit_value, e.value);
				end
				commit_cnt++;
			end
		end
	end

	// ****************************************
	// programs
	// ****************************************

	// prologue sets x1..x7 and the body mixes alu ops and forward branches
	task automatic build_random();
		logic [2:0]  kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  br_f3;
		logic [12:0] br_off;
		for (int i = 1; i < 8; i++) begin
			emit(addi(5'(i), 5'd0, 12'(take_bits(12))));
		end
		for (int i = 0; i < 33; i++) begin
			kind = 3'(take_bits(3));
			rd = 5'(take_bits(3));
			rs1 = 5'(take_bits(3));
			rs2 = 5'(take_bits(3));
			case (kind)
				3'd0:    emit(addi(rd, rs1, 12'(take_bits(12))));
				3'd6:    emit(lui(rd, 20'(take_bits(20))));
				// skip 1 to 4 instructions
				3'd7: begin
					br_f3 = 3'(take_bits(1));
					br_off = 13'((take_bits(2) + 2) * 4);
					emit(branch(br_f3, rs1, rs2, br_off));
				end
				default: emit(rr_op(kind - 3'd1, rd, rs1, rs2));
			endcase
		end
	endtask

	task automatic build_program(input int id);
		prog_end = '0;
		case (id)
			0: begin
				emit(addi(5'd1, 5'd0, 12'd5));
				emit(addi(5'd2, 5'd1, 12'd3));
				emit(rr_op(rr_add, 5'd3, 5'd1, 5'd2));
			end
			// every op reads the result just before it
			1: begin
				emit(addi(5'd1, 5'd0, 12'h123));
				emit(rr_op(rr_add, 5'd2, 5'd1, 5'd1));
				emit(rr_op(rr_sub, 5'd3, 5'd2, 5'd1));
				emit(lui(5'd4, 20'h80001));
				emit(rr_op(rr_xor, 5'd5, 5'd4, 5'd3));
				emit(rr_op(rr_or, 5'd6, 5'd5, 5'd2));
				emit(rr_op(rr_and, 5'd7, 5'd6, 5'd5));
				emit(addi(5'd8, 5'd7, 12'hfff));
				emit(rr_op(rr_sub, 5'd9, 5'd0, 5'd8));
				// same rd back to back
				emit(lui(5'd10, 20'h12345));
				emit(addi(5'd10, 5'd10, 12'h678));
			end
			2: begin
				emit(addi(5'd1, 5'd0, 12'd7));
				emit(addi(5'd0, 5'd1, 12'd1));
				emit(lui(5'd0, 20'h12345));
				emit(rr_op(rr_add, 5'd2, 5'd0, 5'd1));
				emit(rr_op(rr_or, 5'd3, 5'd0, 5'd0));
				emit(rr_op(rr_sub, 5'd0, 5'd1, 5'd1));
				emit(addi(5'd4, 5'd0, 12'd0));
			end
			// wrong-path slots load 0x7ff, 0x7fe, 0x66 and so on
			3: begin
				emit(addi(5'd1, 5'd0, 12'd1));
				emit(addi(5'd2, 5'd0, 12'd1));
				emit(branch(3'b000, 5'd1, 5'd2, 13'd12));
				emit(addi(5'd3, 5'd0, 12'h7ff));
				emit(addi(5'd3, 5'd0, 12'h7fe));
				emit(branch(3'b001, 5'd1, 5'd2, 13'd8));
				emit(addi(5'd4, 5'd0, 12'd4));
				emit(branch(3'b001, 5'd1, 5'd0, 13'd8));
				emit(addi(5'd4, 5'd0, 12'h066));
				emit(branch(3'b000, 5'd1, 5'd0, 13'd8));
				emit(jal(5'd5, 21'd12));
				emit(addi(5'd6, 5'd0, 12'd1));
				emit(addi(5'd6, 5'd0, 12'd2));
				emit(rr_op(rr_add, 5'd7, 5'd5, 5'd4));
				emit(jal(5'd0, 21'd8));
				emit(addi(5'd7, 5'd0, 12'd0));
				emit(addi(5'd8, 5'd7, 12'd1));
			end
			// lw, slli, mul, blt, all ones, all zeros
			4: begin
				emit(addi(5'd1, 5'd0, 12'd9));
				emit({12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011});
				emit({12'h001, 5'd1, 3'b001, 5'd2, 7'b0010011});
				emit({7'h01, 5'd1, 5'd1, 3'b000, 5'd3, 7'b0110011});
				emit(branch(3'b100, 5'd0, 5'd1, 13'd8));
				emit(32'hffff_ffff);
				emit(32'h0000_0000);
				emit(rr_op(rr_add, 5'd4, 5'd1, 5'd0));
			end
			default: build_random();
		endcase
	endtask

	// ****************************************
	// test sequencing
	// ****************************************

	// program swaps while the core is held in reset
	task automatic run_test(input string name, input int id);
		int errors_before;
		@(posedge clk);
		#2;
		rst = 1'b1;
		@(posedge clk);
		#2;
		build_program(id);
		load_count++;
		run_model();
		commit_cnt = 0;
		errors_before = errors;
		budget += 20 * exp_count + 8;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		while (commit_cnt < exp_count) begin
			@(posedge clk);
		end
		tests++;
		if (errors == errors_before) begin
			passed++;
			$display("test %s: pass, %0d commits", name, exp_count);
		end else begin
			$display("test %s: fail, %0d check errors", name, errors - errors_before);
		end
	endtask

	initial begin
		rst = 1'b1;
		prog_end = '0;
		load_count = 0;
		lfsr = 32'h7fb5;
		errors = 0;
		tests = 0;
		passed = 0;
		commit_cnt = 0;
		exp_count = 0;
		run_test("reset_start", 0);
		run_test("dependent_chain", 1);
		run_test("x0_writes", 2);
		run_test("branches_and_jal", 3);
		run_test("unsupported_ops", 4);
		run_test("random_a", 5);
		run_test("random_b", 6);
		run_test("random_c", 7);
		$display("%0d tests run, %0d passed, %0d check errors", tests, passed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// stops a stuck core after 20 cycles per expected commit
	initial begin
		cycles = 0;
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the core stopped retiring", cycles);
		$display("Errors found");
		$finish;
	end

endmodule

/* flist.f */
+incdir+common
common/npc_pkg.sv
common/stage_if.sv
design/regfile.sv
design/scoreboard.sv
ifu/ifu.sv
idu/idu.sv
exu/exu.sv
design/wbu.sv
design/npc.sv
tb/npc_tb.sv

/* Bender.yml */
package:
  name: npc

sources:
  - include_dirs:
      - common
    files:
      - common/npc_pkg.sv
      - common/stage_if.sv
      - design/regfile.sv
      - design/scoreboard.sv
      - ifu/ifu.sv
      - idu/idu.sv
      - exu/exu.sv
      - design/wbu.sv
      - design/npc.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/npc_tb.sv
